//--- project.f
+incdir+src
+incdir+tests
src/isa_pkg.sv
src/pipe_pkg.sv
src/control.sv
src/register_bank.sv
src/decode.sv
src/execute.sv
src/mem_access.sv
src/mips_core.sv
tests/tb_mips_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_core -f project.f
./obj_dir/Vtb_mips_core > sim.log 2>&1 || true
cat sim.log
if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	exit 1
fi

//--- src/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
	input  isa_pkg::opcode_e i_opcode,
	output pipe_pkg::ctrl_t  o_ctrl
);

	always_comb begin
		// unknown opcodes fall through as a nop
		o_ctrl = '0;
		case (i_opcode)
			isa_pkg::OP_RTYPE: begin
				o_ctrl.ex.regdst   = 1'b1;
				o_ctrl.ex.aluop    = pipe_pkg::ALU_FUNCT;
				o_ctrl.wb.regwrite = 1'b1;
			end
			isa_pkg::OP_ADDI: begin
				o_ctrl.ex.alusrc   = 1'b1;
				o_ctrl.ex.aluop    = pipe_pkg::ALU_ADD;
				o_ctrl.wb.regwrite = 1'b1;
			end
			isa_pkg::OP_SLTI: begin
				o_ctrl.ex.alusrc   = 1'b1;
				o_ctrl.ex.aluop    = pipe_pkg::ALU_SUB;
				o_ctrl.ex.other[1] = 1'b1;
				o_ctrl.wb.regwrite = 1'b1;
			end
			isa_pkg::OP_LW: begin
				o_ctrl.ex.alusrc   = 1'b1;
				o_ctrl.ex.aluop    = pipe_pkg::ALU_ADD;
				o_ctrl.mem.memread = 1'b1;
				o_ctrl.wb.memtoreg = 1'b1;
				o_ctrl.wb.regwrite = 1'b1;
			end
			isa_pkg::OP_SW: begin
				o_ctrl.ex.alusrc    = 1'b1;
				o_ctrl.ex.aluop     = pipe_pkg::ALU_ADD;
				o_ctrl.mem.memwrite = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				o_ctrl.ex.aluop   = pipe_pkg::ALU_SUB;
				o_ctrl.mem.branch = 1'b1;
			end
			isa_pkg::OP_BNE: begin
				o_ctrl.ex.aluop    = pipe_pkg::ALU_SUB;
				o_ctrl.ex.other[0] = 1'b1;
				o_ctrl.mem.branch  = 1'b1;
			end
			default: begin
				o_ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module decode (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  isa_pkg::instr_t    i_instr,
	input  logic [`DATA_W-1:0] i_next_pc,
	input  pipe_pkg::wb_t      i_wb,
	output pipe_pkg::id_ex_t   o_id_ex
);

	// ==============================
	// combinational decode
	// ==============================
	pipe_pkg::ctrl_t    ctrl;
	logic [`DATA_W-1:0] rs_val;
	logic [`DATA_W-1:0] rt_val;
	logic [`DATA_W-1:0] imm_ext;
	pipe_pkg::id_ex_t   id_ex_d;

	control u_control (
		.i_opcode (i_instr.opcode),
		.o_ctrl   (ctrl)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_rs_addr (i_instr.rs),
		.i_rt_addr (i_instr.rt),
		.i_wb      (i_wb),
		.o_rs_data (rs_val),
		.o_rt_data (rt_val)
	);

	// sign extension of the 16-bit immediate
	assign imm_ext = {{(`DATA_W-16){i_instr.low.imm[15]}}, i_instr.low.imm};

	always_comb begin
		id_ex_d.ctrl    = ctrl;
		id_ex_d.next_pc = i_next_pc;
		id_ex_d.rs_val  = rs_val;
		id_ex_d.rt_val  = rt_val;
		id_ex_d.imm     = imm_ext;
		// execute picks one of the two destination candidates
		id_ex_d.rt_num  = i_instr.rt;
		id_ex_d.rd_num  = i_instr.low.r.rd;
	end

	// ==============================
	// id/ex register
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex <= id_ex_d;
		end
	end

endmodule

`default_nettype wire

//--- src/execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module execute (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  pipe_pkg::id_ex_t   i_id_ex,
	output pipe_pkg::ex_mem_t  o_ex_mem,
	output logic               o_redirect_valid,
	output logic [`DATA_W-1:0] o_redirect_pc
);

	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic               less;
	logic [`DATA_W-1:0] alu_res;
	isa_pkg::funct_e    funct;
	logic               taken;
	logic [`DATA_W-1:0] target;
	pipe_pkg::ex_mem_t  ex_mem_d;

	// ==============================
	// alu
	// ==============================
	assign op_a  = i_id_ex.rs_val;
	assign op_b  = i_id_ex.ctrl.ex.alusrc ? i_id_ex.imm : i_id_ex.rt_val;
	assign less  = $signed(op_a) < $signed(op_b);
	// funct sits in the low bits of the extended immediate
	assign funct = isa_pkg::funct_e'(i_id_ex.imm[5:0]);

	always_comb begin
		case (i_id_ex.ctrl.ex.aluop)
			pipe_pkg::ALU_ADD: alu_res = op_a + op_b;
			pipe_pkg::ALU_SUB: begin
				if (i_id_ex.ctrl.ex.other[1]) begin
					alu_res = {{(`DATA_W-1){1'b0}}, less};
				end else begin
					alu_res = op_a - op_b;
				end
			end
			pipe_pkg::ALU_FUNCT: begin
				case (funct)
					isa_pkg::FN_ADD: alu_res = op_a + op_b;
					isa_pkg::FN_SUB: alu_res = op_a - op_b;
					isa_pkg::FN_AND: alu_res = op_a & op_b;
					isa_pkg::FN_OR:  alu_res = op_a | op_b;
					isa_pkg::FN_SLT: alu_res = {{(`DATA_W-1){1'b0}}, less};
					default:         alu_res = '0;
				endcase
			end
			default: alu_res = '0;
		endcase
	end

	// other[0] turns beq into bne
	assign taken  = i_id_ex.ctrl.mem.branch &
		((i_id_ex.rs_val == i_id_ex.rt_val) ^ i_id_ex.ctrl.ex.other[0]);
	assign target = i_id_ex.next_pc + {i_id_ex.imm[`DATA_W-3:0], 2'b00};

	always_comb begin
		ex_mem_d.mem        = i_id_ex.ctrl.mem;
		ex_mem_d.wb         = i_id_ex.ctrl.wb;
		ex_mem_d.alu_res    = alu_res;
		ex_mem_d.store_data = i_id_ex.rt_val;
		ex_mem_d.dst        = i_id_ex.ctrl.ex.regdst ? i_id_ex.rd_num : i_id_ex.rt_num;
	end

	// ==============================
	// ex/mem register and redirect
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ex_mem         <= '0;
			o_redirect_valid <= 1'b0;
			o_redirect_pc    <= '0;
		end else begin
			o_ex_mem         <= ex_mem_d;
			o_redirect_valid <= taken;
			o_redirect_pc    <= target;
		end
	end

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_BEQ   = 6'd4,
		OP_BNE   = 6'd5,
		OP_ADDI  = 6'd8,
		OP_SLTI  = 6'd10,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_e;

	// r-type function codes
	typedef enum logic [5:0] {
		FN_ADD = 6'd32,
		FN_SUB = 6'd34,
		FN_AND = 6'd36,
		FN_OR  = 6'd37,
		FN_SLT = 6'd42
	} funct_e;

	// low half, r-type view
	typedef struct packed {
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} rfields_t;

	// low half seen either as r-type fields or as the i-type immediate
	typedef union packed {
		rfields_t    r;
		logic [15:0] imm;
	} low_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		low_t       low;
	} instr_t;

endpackage

`default_nettype wire

//--- src/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module mem_access (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  pipe_pkg::ex_mem_t i_ex_mem,
	output pipe_pkg::wb_t     o_wb
);

	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;
	logic [`DATA_W-1:0] load_data;

	// byte address to word index
	assign word_idx  = i_ex_mem.alu_res[DMEM_AW+1:2];
	assign load_data = i_ex_mem.mem.memread ? dmem[word_idx] : '0;

	// ==============================
	// data memory
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (i_ex_mem.mem.memwrite) begin
			dmem[word_idx] <= i_ex_mem.store_data;
		end
	end

	// ==============================
	// write-back port
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb <= '0;
		end else begin
			// writes to r0 are dropped here
			o_wb.en   <= i_ex_mem.wb.regwrite && (i_ex_mem.dst != '0);
			o_wb.addr <= i_ex_mem.dst;
			o_wb.data <= i_ex_mem.wb.memtoreg ? load_data : i_ex_mem.alu_res;
		end
	end

endmodule

`default_nettype wire

//--- src/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module mips_core (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  isa_pkg::instr_t    i_instr,
	input  logic [`DATA_W-1:0] i_next_pc,
	output pipe_pkg::wb_t      o_wb,
	output logic               o_redirect_valid,
	output logic [`DATA_W-1:0] o_redirect_pc
);

	pipe_pkg::id_ex_t  id_ex;
	pipe_pkg::ex_mem_t ex_mem;

	// ==============================
	// stages
	// ==============================

	// write-back loops back into the register bank
	decode u_decode (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_instr   (i_instr),
		.i_next_pc (i_next_pc),
		.i_wb      (o_wb),
		.o_id_ex   (id_ex)
	);

	execute u_execute (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_id_ex          (id_ex),
		.o_ex_mem         (ex_mem),
		.o_redirect_valid (o_redirect_valid),
		.o_redirect_pc    (o_redirect_pc)
	);

	mem_access u_mem_access (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_ex_mem (ex_mem),
		.o_wb     (o_wb)
	);

endmodule

`default_nettype wire

//--- src/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ==============================
// datapath sizes
// ==============================

// width of a data word and of the pc
`define DATA_W 32

// register file shape
`define REG_COUNT 32
`define REG_AW 5

// data memory depth in words
`define DMEM_WORDS 64

`endif

//--- src/pipe_pkg.sv
`default_nettype none

`include "mips_settings.svh"

package pipe_pkg;

	typedef enum logic [1:0] {
		ALU_ADD   = 2'b00,
		ALU_SUB   = 2'b01,
		ALU_FUNCT = 2'b10
	} aluop_e;

	// ==============================
	// control groups
	// ==============================

	// other[0] flips beq into bne, other[1] turns sub into slt
	typedef struct packed {
		logic       regdst;
		logic       alusrc;
		aluop_e     aluop;
		logic [1:0] other;
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic memread;
		logic memwrite;
	} mem_ctrl_t;

	typedef struct packed {
		logic memtoreg;
		logic regwrite;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_t;

	// ==============================
	// stage payloads
	// ==============================

	typedef struct packed {
		ctrl_t              ctrl;
		logic [`DATA_W-1:0] next_pc;
		logic [`DATA_W-1:0] rs_val;
		logic [`DATA_W-1:0] rt_val;
		logic [`DATA_W-1:0] imm;
		logic [`REG_AW-1:0] rt_num;
		logic [`REG_AW-1:0] rd_num;
	} id_ex_t;

	typedef struct packed {
		mem_ctrl_t          mem;
		wb_ctrl_t           wb;
		logic [`DATA_W-1:0] alu_res;
		logic [`DATA_W-1:0] store_data;
		logic [`REG_AW-1:0] dst;
	} ex_mem_t;

	// register file write port
	typedef struct packed {
		logic               en;
		logic [`REG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

//--- src/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module register_bank (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic [`REG_AW-1:0] i_rs_addr,
	input  logic [`REG_AW-1:0] i_rt_addr,
	input  pipe_pkg::wb_t      i_wb,
	output logic [`DATA_W-1:0] o_rs_data,
	output logic [`DATA_W-1:0] o_rt_data
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// r0 always reads as zero
	// a pending write to the same register wins over the stored value
	function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_AW-1:0] addr);
		logic [`DATA_W-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (i_wb.en && (i_wb.addr == addr)) begin
			val = i_wb.data;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_comb begin
		o_rs_data = read_port(i_rs_addr);
		o_rt_data = read_port(i_rt_addr);
	end

	// ==============================
	// write port
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.en && (i_wb.addr != '0)) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_model.svh
// ==============================
// golden state and random source
// ==============================
logic [`DATA_W-1:0] gold_regs [`REG_COUNT];
logic [`DATA_W-1:0] gold_mem [`DMEM_WORDS];
logic [31:0]        lfsr_state;

// fibonacci lfsr with taps 32 22 2 1
// one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
	logic [31:0] val;
	logic        fb;
	val = '0;
	for (int i = 0; i < n; i++) begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		val        = {val[30:0], fb};
	end
	return val;
endfunction

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
	return {6'd0, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// one random instruction from the supported set
function automatic logic [31:0] random_word();
	int          kind;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;
	kind = lfsr_bits(4) % 11;
	rs   = 5'(lfsr_bits(5));
	rt   = 5'(lfsr_bits(5));
	rd   = 5'(lfsr_bits(5));
	imm  = 16'(lfsr_bits(16));
	case (kind)
		0: return enc_r(isa_pkg::FN_ADD, rs, rt, rd);
		1: return enc_r(isa_pkg::FN_SUB, rs, rt, rd);
		2: return enc_r(isa_pkg::FN_AND, rs, rt, rd);
		3: return enc_r(isa_pkg::FN_OR, rs, rt, rd);
		4: return enc_r(isa_pkg::FN_SLT, rs, rt, rd);
		5: return enc_i(isa_pkg::OP_ADDI, rs, rt, imm);
		6: return enc_i(isa_pkg::OP_SLTI, rs, rt, imm);
		7: return enc_i(isa_pkg::OP_LW, rs, rt, imm);
		8: return enc_i(isa_pkg::OP_SW, rs, rt, imm);
		9: return enc_i(isa_pkg::OP_BEQ, rs, rt, imm);
		default: return enc_i(isa_pkg::OP_BNE, rs, rt, imm);
	endcase
endfunction

// architectural effect of one instruction on the golden state
function automatic void model_step(
	input  logic [`DATA_W-1:0] word,
	input  logic [`DATA_W-1:0] npc,
	output pipe_pkg::wb_t      wb,
	output logic               redir,
	output logic [`DATA_W-1:0] redir_pc
);
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	logic [`DATA_W-1:0] imm;
	a        = gold_regs[word[25:21]];
	b        = gold_regs[word[20:16]];
	imm      = {{16{word[15]}}, word[15:0]};
	wb       = '0;
	wb.addr  = word[20:16];
	redir    = 1'b0;
	redir_pc = npc + (imm << 2);
	case (word[31:26])
		isa_pkg::OP_RTYPE: begin
			wb.en   = 1'b1;
			wb.addr = word[15:11];
			case (word[5:0])
				isa_pkg::FN_ADD: wb.data = a + b;
				isa_pkg::FN_SUB: wb.data = a - b;
				isa_pkg::FN_AND: wb.data = a & b;
				isa_pkg::FN_OR:  wb.data = a | b;
				default:         wb.data = {31'd0, $signed(a) < $signed(b)};
			endcase
		end
		isa_pkg::OP_ADDI: {wb.en, wb.data} = {1'b1, a + imm};
		isa_pkg::OP_SLTI: {wb.en, wb.data} = {1'b1, 31'd0, $signed(a) < $signed(imm)};
		isa_pkg::OP_LW:   {wb.en, wb.data} = {1'b1, gold_mem[((a + imm) >> 2) % `DMEM_WORDS]};
		isa_pkg::OP_SW:   gold_mem[((a + imm) >> 2) % `DMEM_WORDS] = b;
		isa_pkg::OP_BEQ:  redir = (a == b);
		isa_pkg::OP_BNE:  redir = (a != b);
		default:          wb.en = 1'b0;
	endcase
	// r0 is never written
	if (wb.addr == '0) begin
		wb.en = 1'b0;
	end
	if (wb.en) begin
		gold_regs[wb.addr] = wb.data;
	end
endfunction

//--- tests/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module tb_mips_core;

	typedef struct packed {
		int                 issue;
		pipe_pkg::wb_t      wb;
		logic               redir;
		logic [`DATA_W-1:0] redir_pc;
	} expect_t;

	logic               i_clk;
	logic               i_rst_n;
	isa_pkg::instr_t    i_instr;
	logic [`DATA_W-1:0] i_next_pc;
	pipe_pkg::wb_t      o_wb;
	logic               o_redirect_valid;
	logic [`DATA_W-1:0] o_redirect_pc;

	expect_t            wb_q[$];
	expect_t            br_q[$];
	int                 cyc = 0;
	int                 last_issue;
	int                 last_wr [`REG_COUNT];
	logic [`DATA_W-1:0] pc;

	`include "tb_model.svh"

	mips_core i_dut (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_instr          (i_instr),
		.i_next_pc        (i_next_pc),
		.o_wb             (o_wb),
		.o_redirect_valid (o_redirect_valid),
		.o_redirect_pc    (o_redirect_pc)
	);

	always #20 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cyc <= cyc + 1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// ==============================
	// output checks at the falling edge
	// ==============================
	task automatic check_wb();
		expect_t e;
		if (wb_q.size() != 0 && wb_q[0].issue + 3 == cyc) begin
			e = wb_q.pop_front();
			assert (o_wb.en == e.wb.en) else report_failure(
				$sformatf("MISMATCH o_wb.en expected %h got %h", e.wb.en, o_wb.en));
			if (e.wb.en) begin
				assert (o_wb.addr == e.wb.addr) else report_failure(
					$sformatf("MISMATCH o_wb.addr expected %h got %h", e.wb.addr, o_wb.addr));
				assert (o_wb.data == e.wb.data) else report_failure(
					$sformatf("MISMATCH o_wb.data expected %h got %h", e.wb.data, o_wb.data));
			end
		end else begin
			assert (!o_wb.en) else report_failure("write-back enabled with no instruction due");
		end
	endtask

	task automatic check_redirect();
		expect_t e;
		if (br_q.size() != 0 && br_q[0].issue + 2 == cyc) begin
			e = br_q.pop_front();
			assert (o_redirect_valid == e.redir) else report_failure($sformatf(
				"MISMATCH o_redirect_valid expected %h got %h", e.redir, o_redirect_valid));
			if (e.redir) begin
				assert (o_redirect_pc == e.redir_pc) else report_failure($sformatf(
					"MISMATCH o_redirect_pc expected %h got %h", e.redir_pc, o_redirect_pc));
			end
		end else begin
			assert (!o_redirect_valid) else report_failure("redirect raised with no branch due");
		end
	endtask

	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			assert (!o_wb.en && !o_redirect_valid)
				else report_failure("write-back or redirect active during reset");
		end else begin
			check_wb();
			check_redirect();
		end
	end

	// ==============================
	// stimulus
	// ==============================
	task automatic drive_slot(input logic [`DATA_W-1:0] word);
		expect_t e;
		@(posedge i_clk);
		i_instr   <= isa_pkg::instr_t'(word);
		i_next_pc <= pc + 4;
		e.issue    = cyc + 1;
		model_step(word, pc + 4, e.wb, e.redir, e.redir_pc);
		if (e.wb.en) begin
			last_wr[e.wb.addr] = e.issue;
		end
		last_issue = e.issue;
		pc         = pc + 4;
		wb_q.push_back(e);
		br_q.push_back(e);
	endtask

	// nops until both sources are three slots past their writer
	task automatic issue(input logic [`DATA_W-1:0] word);
		int ready;
		ready = last_wr[word[25:21]] + 3;
		if (last_wr[word[20:16]] + 3 > ready) begin
			ready = last_wr[word[20:16]] + 3;
		end
		while (last_issue + 1 < ready) begin
			drive_slot('0);
		end
		drive_slot(word);
	endtask

	initial begin
		int waited;
		i_clk      = 1'b0;
		i_rst_n    = 1'b0;
		i_instr    = '0;
		i_next_pc  = '0;
		pc         = '0;
		last_issue = 0;
		lfsr_state = 32'h6686;
		for (int r = 0; r < `REG_COUNT; r++) begin
			gold_regs[r] = '0;
			last_wr[r]   = -100;
		end
		for (int w = 0; w < `DMEM_WORDS; w++) begin
			gold_mem[w] = '0;
		end
		repeat (4) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// seed every register with a random immediate
		for (int r = 1; r < `REG_COUNT; r++) begin
			issue(enc_i(isa_pkg::OP_ADDI, 5'd0, 5'(r), 16'(lfsr_bits(16))));
		end
		// dependent chain through the bank bypass
		issue(enc_r(isa_pkg::FN_ADD, 5'd2, 5'd3, 5'd1));
		issue(enc_r(isa_pkg::FN_SUB, 5'd1, 5'd4, 5'd1));
		issue(enc_r(isa_pkg::FN_OR, 5'd1, 5'd1, 5'd5));
		issue(enc_i(isa_pkg::OP_SLTI, 5'd5, 5'd9, 16'hfff3));
		// store then load of one word
		issue(enc_i(isa_pkg::OP_SW, 5'd0, 5'd5, 16'h0010));
		issue(enc_i(isa_pkg::OP_LW, 5'd0, 5'd6, 16'h0010));
		// branches taken and not taken
		issue(enc_i(isa_pkg::OP_BEQ, 5'd0, 5'd0, 16'hfff0));
		issue(enc_i(isa_pkg::OP_BNE, 5'd0, 5'd0, 16'h0004));
		issue(enc_i(isa_pkg::OP_BNE, 5'd7, 5'd0, 16'h0008));
		issue(enc_i(isa_pkg::OP_BEQ, 5'd7, 5'd0, 16'h0003));
		// writes aimed at r0 and a later read of it
		issue(enc_i(isa_pkg::OP_ADDI, 5'd0, 5'd0, 16'h1234));
		issue(enc_r(isa_pkg::FN_ADD, 5'd3, 5'd3, 5'd0));
		issue(enc_r(isa_pkg::FN_OR, 5'd0, 5'd0, 5'd8));
		for (int n = 0; n < 300; n++) begin
			issue(random_word());
		end

		@(posedge i_clk);
		i_instr <= '0;
		waited = 0;
		while ((wb_q.size() != 0 || br_q.size() != 0) && waited < 10) begin
			@(posedge i_clk);
			waited++;
		end
		if (wb_q.size() != 0 || br_q.size() != 0) begin
			report_failure("timeout while waiting for the pipeline to drain");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
